// File: rtl/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

  // Bits in one byte on the bus.
  localparam int byte_w = 8;

  // R/W bit value that selects a read from the slave.
  localparam logic rw_read = 1'b1;

  // Slave engine states.
  typedef enum logic [2:0] {
    st_idle,
    st_addr,
    st_addr_ack,
    st_rx_byte,
    st_rx_ack,
    st_tx_byte,
    st_tx_ack,
    st_skip
  } slave_state_e;

  // Conditioned bus events, all pulses are one clk cycle wide.
  typedef struct packed {
    logic start;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda;
  } line_evt_t;

endpackage

`default_nettype wire

// File: rtl/i2c_line_cond.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_line_cond (
  input  logic               clk,
  input  logic               rst,
  input  logic               scl_i,
  input  logic               sda_i,
  output i2c_pkg::line_evt_t evt_o
);

  logic scl_s1;
  logic scl_s2;
  logic scl_d;
  logic sda_s1;
  logic sda_s2;
  logic sda_d;

  logic scl_rise_c;
  logic scl_fall_c;
  logic start_c;
  logic stop_c;

  logic start_q;
  logic stop_q;
  logic scl_rise_q;
  logic scl_fall_q;

  // Two synchronizer stages plus one stage of history.
  // Idle bus is high, so that is the reset level.
  always_ff @(posedge clk) begin
    if (!rst) begin
      scl_s1 <= 1'b1;
      scl_s2 <= 1'b1;
      scl_d  <= 1'b1;
      sda_s1 <= 1'b1;
      sda_s2 <= 1'b1;
      sda_d  <= 1'b1;
    end else begin
      scl_s1 <= scl_i;
      scl_s2 <= scl_s1;
      scl_d  <= scl_s2;
      sda_s1 <= sda_i;
      sda_s2 <= sda_s1;
      sda_d  <= sda_s2;
    end
  end

  assign scl_rise_c = scl_s2 & ~scl_d;
  assign scl_fall_c = ~scl_s2 & scl_d;

  // SDA moving while SCL stays high marks START or STOP.
  assign start_c = scl_s2 & scl_d & sda_d & ~sda_s2;
  assign stop_c  = scl_s2 & scl_d & ~sda_d & sda_s2;

  always_ff @(posedge clk) begin
    if (!rst) begin
      start_q    <= 1'b0;
      stop_q     <= 1'b0;
      scl_rise_q <= 1'b0;
      scl_fall_q <= 1'b0;
    end else begin
      start_q    <= start_c;
      stop_q     <= stop_c;
      scl_rise_q <= scl_rise_c;
      scl_fall_q <= scl_fall_c;
    end
  end

  assign evt_o = '{start: start_q, stop: stop_q, scl_rise: scl_rise_q,
                   scl_fall: scl_fall_q, sda: sda_s2};

endmodule

`default_nettype wire

// File: rtl/i2c_slave_engine.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_slave_engine #(
  parameter logic [6:0] DEV_ADDR = 7'h25
) (
  input  logic                       clk,
  input  logic                       rst,
  input  i2c_pkg::line_evt_t         evt_i,
  input  logic [i2c_pkg::byte_w-1:0] tx_byte_i,
  output logic [i2c_pkg::byte_w-1:0] rx_byte_o,
  output logic                       rx_valid_o,
  output logic                       tx_take_o,
  output logic                       sess_start_o,
  output logic                       sda_oe_o
);

  localparam int CNT_W = $clog2(i2c_pkg::byte_w + 1);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(i2c_pkg::byte_w);

  i2c_pkg::slave_state_e state;

  logic [CNT_W-1:0]          bit_cnt;
  logic [i2c_pkg::byte_w-1:0] shreg;
  logic                       rw_q;

  logic byte_done;
  logic addr_hit;
  logic tx_begin;
  logic rx_shift;
  logic tx_shift;

  assign byte_done = (bit_cnt == BIT_LAST);
  assign addr_hit  = (shreg[i2c_pkg::byte_w-1:1] == DEV_ADDR);

  // A send byte starts on the falling SCL after our address ACK (read)
  // or after the master has acknowledged the previous byte.
  assign tx_begin = evt_i.scl_fall &&
                    (((state == i2c_pkg::st_addr_ack) && (rw_q == i2c_pkg::rw_read)) ||
                     (state == i2c_pkg::st_tx_ack));

  assign rx_shift = evt_i.scl_rise &&
                    ((state == i2c_pkg::st_addr) || (state == i2c_pkg::st_rx_byte));
  assign tx_shift = evt_i.scl_rise && (state == i2c_pkg::st_tx_byte);

  // Data path.
  always_ff @(posedge clk) begin
    if (rx_shift) begin
      shreg <= {shreg[i2c_pkg::byte_w-2:0], evt_i.sda};
    end else if (tx_shift) begin
      shreg <= {shreg[i2c_pkg::byte_w-2:0], 1'b0};
    end else if (tx_begin) begin
      shreg <= tx_byte_i;
    end

    if (evt_i.scl_fall && byte_done && (state == i2c_pkg::st_rx_byte)) begin
      rx_byte_o <= shreg;
    end
  end

  // Control FSM.
  always_ff @(posedge clk) begin
    if (!rst) begin
      state        <= i2c_pkg::st_idle;
      bit_cnt      <= '0;
      rw_q         <= 1'b0;
      sda_oe_o     <= 1'b0;
      rx_valid_o   <= 1'b0;
      tx_take_o    <= 1'b0;
      sess_start_o <= 1'b0;
    end else begin
      rx_valid_o   <= 1'b0;
      tx_take_o    <= 1'b0;
      sess_start_o <= 1'b0;

      if (evt_i.start) begin
        // Repeated START just opens a new address phase.
        state    <= i2c_pkg::st_addr;
        bit_cnt  <= '0;
        sda_oe_o <= 1'b0;
      end else if (evt_i.stop) begin
        state    <= i2c_pkg::st_idle;
        bit_cnt  <= '0;
        sda_oe_o <= 1'b0;
      end else begin
        case (state)
          i2c_pkg::st_addr: begin
            if (evt_i.scl_rise) begin
              bit_cnt <= bit_cnt + 1'b1;
            end else if (evt_i.scl_fall && byte_done) begin
              bit_cnt <= '0;
              if (addr_hit) begin
                rw_q         <= shreg[0];
                sda_oe_o     <= 1'b1;
                sess_start_o <= 1'b1;
                state        <= i2c_pkg::st_addr_ack;
              end else begin
                // Foreign address, stay off the bus until next START.
                state <= i2c_pkg::st_skip;
              end
            end
          end

          i2c_pkg::st_addr_ack: begin
            if (tx_begin) begin
              sda_oe_o  <= ~tx_byte_i[i2c_pkg::byte_w-1];
              tx_take_o <= 1'b1;
              state     <= i2c_pkg::st_tx_byte;
            end else if (evt_i.scl_fall) begin
              sda_oe_o <= 1'b0;
              state    <= i2c_pkg::st_rx_byte;
            end
          end

          i2c_pkg::st_rx_byte: begin
            if (evt_i.scl_rise) begin
              bit_cnt <= bit_cnt + 1'b1;
            end else if (evt_i.scl_fall && byte_done) begin
              bit_cnt    <= '0;
              sda_oe_o   <= 1'b1;
              rx_valid_o <= 1'b1;
              state      <= i2c_pkg::st_rx_ack;
            end
          end

          i2c_pkg::st_rx_ack: begin
            if (evt_i.scl_fall) begin
              sda_oe_o <= 1'b0;
              state    <= i2c_pkg::st_rx_byte;
            end
          end

          i2c_pkg::st_tx_byte: begin
            if (evt_i.scl_rise) begin
              bit_cnt <= bit_cnt + 1'b1;
            end else if (evt_i.scl_fall) begin
              if (byte_done) begin
                // Hand SDA to the master for its ACK.
                bit_cnt  <= '0;
                sda_oe_o <= 1'b0;
                state    <= i2c_pkg::st_tx_ack;
              end else begin
                sda_oe_o <= ~shreg[i2c_pkg::byte_w-1];
              end
            end
          end

          i2c_pkg::st_tx_ack: begin
            if (evt_i.scl_rise && evt_i.sda) begin
              // Master NACK ends the read.
              state <= i2c_pkg::st_skip;
            end else if (tx_begin) begin
              sda_oe_o  <= ~tx_byte_i[i2c_pkg::byte_w-1];
              tx_take_o <= 1'b1;
              state     <= i2c_pkg::st_tx_byte;
            end
          end

          default: begin
            // Idle and skip wait for START or STOP.
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/i2c_mailbox.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_mailbox #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [i2c_pkg::byte_w-1:0] rx_byte_i,
  input  logic                       rx_valid_i,
  input  logic                       tx_take_i,
  input  logic                       sess_start_i,
  output logic [i2c_pkg::byte_w-1:0] tx_byte_o,
  input  logic [DATA_WIDTH-1:0]      word_i,
  input  logic                       word_load_i,
  output logic [DATA_WIDTH-1:0]      word_o,
  output logic                       word_valid_o
);

  localparam int NBYTES = DATA_WIDTH / i2c_pkg::byte_w;
  localparam int IDX_W  = (NBYTES > 1) ? $clog2(NBYTES) : 1;
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(NBYTES - 1);

  logic [DATA_WIDTH-1:0] asm_q;
  logic [DATA_WIDTH-1:0] asm_next;
  logic [DATA_WIDTH-1:0] rd_word_q;
  logic [IDX_W-1:0]      rx_cnt;
  logic [IDX_W-1:0]      tx_idx;
  logic [IDX_W-1:0]      tx_sel;
  logic                  word_done;

  // Bytes arrive MSB first, so each new one goes in at the bottom.
  assign asm_next  = (asm_q << i2c_pkg::byte_w) | DATA_WIDTH'(rx_byte_i);
  assign word_done = rx_valid_i && (rx_cnt == IDX_LAST);

  always_ff @(posedge clk) begin
    if (!rst) begin
      rx_cnt       <= '0;
      tx_idx       <= '0;
      word_valid_o <= 1'b0;
    end else begin
      word_valid_o <= 1'b0;
      if (sess_start_i) begin
        rx_cnt <= '0;
        tx_idx <= '0;
      end else begin
        if (rx_valid_i) begin
          if (word_done) begin
            rx_cnt       <= '0;
            word_valid_o <= 1'b1;
          end else begin
            rx_cnt <= rx_cnt + 1'b1;
          end
        end
        if (tx_take_i) begin
          tx_idx <= (tx_idx == IDX_LAST) ? '0 : tx_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid_i) begin
      asm_q <= asm_next;
    end
    if (word_done) begin
      word_o <= asm_next;
    end
    if (word_load_i) begin
      rd_word_q <= word_i;
    end
  end

  // Index 0 is the most significant byte.
  assign tx_sel    = IDX_LAST - tx_idx;
  assign tx_byte_o = rd_word_q[tx_sel*i2c_pkg::byte_w +: i2c_pkg::byte_w];

endmodule

`default_nettype wire

// File: rtl/i2c_slave_top.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_slave_top #(
  parameter logic [6:0] DEV_ADDR   = 7'h25,
  parameter int         DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  scl_i,
  input  logic                  sda_i,
  output logic                  sda_oe_o,
  output logic [DATA_WIDTH-1:0] word_o,
  output logic                  word_valid_o,
  input  logic [DATA_WIDTH-1:0] word_i,
  input  logic                  word_load_i
);

  i2c_pkg::line_evt_t         evt;
  logic [i2c_pkg::byte_w-1:0] rx_byte;
  logic [i2c_pkg::byte_w-1:0] tx_byte;
  logic                       rx_valid;
  logic                       tx_take;
  logic                       sess_start;

  i2c_line_cond line_cond_i (
    .clk   (clk),
    .rst   (rst),
    .scl_i (scl_i),
    .sda_i (sda_i),
    .evt_o (evt)
  );

  i2c_slave_engine #(
    .DEV_ADDR (DEV_ADDR)
  ) engine_i (
    .clk          (clk),
    .rst          (rst),
    .evt_i        (evt),
    .tx_byte_i    (tx_byte),
    .rx_byte_o    (rx_byte),
    .rx_valid_o   (rx_valid),
    .tx_take_o    (tx_take),
    .sess_start_o (sess_start),
    .sda_oe_o     (sda_oe_o)
  );

  i2c_mailbox #(
    .DATA_WIDTH (DATA_WIDTH)
  ) mailbox_i (
    .clk          (clk),
    .rst          (rst),
    .rx_byte_i    (rx_byte),
    .rx_valid_i   (rx_valid),
    .tx_take_i    (tx_take),
    .sess_start_i (sess_start),
    .tx_byte_o    (tx_byte),
    .word_i       (word_i),
    .word_load_i  (word_load_i),
    .word_o       (word_o),
    .word_valid_o (word_valid_o)
  );

endmodule

`default_nettype wire

// File: test/i2c_slave_chk.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_slave_chk (
  input logic                  clk,
  input logic                  rst,
  input i2c_pkg::slave_state_e state_i,
  input i2c_pkg::line_evt_t    evt_i,
  input logic                  sda_oe_i,
  input logic                  rx_valid_i,
  input logic                  tx_take_i
);

  int fail_cnt = 0;

  // Engine stays off the bus while idle or skipping.
  idle_release_a: assert property (@(posedge clk) disable iff (!rst)
    ((state_i == i2c_pkg::st_idle) || (state_i == i2c_pkg::st_skip)) |-> !sda_oe_i)
    else begin
      $error("sda_oe_o is high in the idle or skip state");
      fail_cnt = fail_cnt + 1;
    end

  // The SDA driver only moves right after SCL falls, START or STOP.
  oe_timing_a: assert property (@(posedge clk) disable iff (!rst)
    $changed(sda_oe_i) |-> $past(evt_i.scl_fall || evt_i.start || evt_i.stop))
    else begin
      $error("sda_oe_o changed without a preceding scl_fall, start or stop");
      fail_cnt = fail_cnt + 1;
    end

  rx_tx_excl_a: assert property (@(posedge clk) disable iff (!rst)
    !(rx_valid_i && tx_take_i))
    else begin
      $error("rx_valid_o and tx_take_o are high in the same cycle");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind i2c_slave_engine i2c_slave_chk chk_i (
  .clk        (clk),
  .rst        (rst),
  .state_i    (state),
  .evt_i      (evt_i),
  .sda_oe_i   (sda_oe_o),
  .rx_valid_i (rx_valid_o),
  .tx_take_i  (tx_take_o)
);

`default_nettype wire

// File: test/i2c_slave_mon.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_slave_mon #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  scl_i,
  input  logic                  sda_i,
  input  logic                  sda_oe_i,
  input  logic [DATA_WIDTH-1:0] word_i,
  input  logic                  word_valid_i,
  input  logic                  exp_ack_i,
  input  logic [DATA_WIDTH-1:0] exp_wr_word_i,
  input  logic [DATA_WIDTH-1:0] exp_rd_word_i,
  input  int                    exp_words_i,
  output int                    err_cnt_o,
  output int                    chk_cnt_o
);

  localparam int NBYTES = DATA_WIDTH / i2c_pkg::byte_w;
  localparam int SETTLE = 8;

  logic                       scl_d;
  logic                       sda_d;
  logic                       in_xfer;
  logic                       rw_q;
  logic                       nacked;
  logic [i2c_pkg::byte_w-1:0] shreg;
  logic [i2c_pkg::byte_w-1:0] exp_byte;
  int                         idle_cnt;
  int                         bit_cnt;
  int                         byte_idx;
  int                         words_seen;

  task automatic compare(input string name, input logic [DATA_WIDTH-1:0] exp,
                         input logic [DATA_WIDTH-1:0] act);
    chk_cnt_o = chk_cnt_o + 1;
    if (act !== exp) begin
      err_cnt_o = err_cnt_o + 1;
      $display("[FAIL] %0t ns %s: expected %0h, actual %0h", $time, name, exp, act);
    end
  endtask

  // Runs on each rising SCL. Eight data bits are followed by the ACK slot.
  task automatic sample_bit();
    if (!exp_ack_i) begin
      compare("sda_oe_o", 1'b0, sda_oe_i);
    end
    if (bit_cnt < i2c_pkg::byte_w) begin
      shreg = {shreg[i2c_pkg::byte_w-2:0], sda_i};
      bit_cnt = bit_cnt + 1;
      if ((bit_cnt == i2c_pkg::byte_w) && (byte_idx == 0)) begin
        rw_q = shreg[0];
      end else if ((bit_cnt == i2c_pkg::byte_w) && (rw_q == i2c_pkg::rw_read) && exp_ack_i) begin
        // Read bytes come MSB first and wrap after the last one.
        exp_byte = exp_rd_word_i[(NBYTES - 1 - (byte_idx - 1) % NBYTES) * i2c_pkg::byte_w
                                 +: i2c_pkg::byte_w];
        compare("read byte", exp_byte, shreg);
      end
    end else begin
      if (byte_idx == 0) begin
        compare("address ACK", !exp_ack_i, sda_i);
      end else if ((rw_q != i2c_pkg::rw_read) || !exp_ack_i) begin
        compare("write byte ACK", !exp_ack_i, sda_i);
      end else if (sda_i) begin
        nacked = 1'b1;
      end
      bit_cnt = 0;
      byte_idx = byte_idx + 1;
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      scl_d      = 1'b1;
      sda_d      = 1'b1;
      in_xfer    = 1'b0;
      rw_q       = 1'b0;
      nacked     = 1'b0;
      shreg      = '0;
      idle_cnt   = 0;
      bit_cnt    = 0;
      byte_idx   = 0;
      words_seen = 0;
      err_cnt_o  = 0;
      chk_cnt_o  = 0;
    end else begin
      if (scl_i && scl_d && sda_d && !sda_i) begin
        in_xfer  = 1'b1;
        nacked   = 1'b0;
        bit_cnt  = 0;
        byte_idx = 0;
      end else if (scl_i && scl_d && !sda_d && sda_i) begin
        compare("word_valid_o pulses", exp_words_i, words_seen);
        in_xfer    = 1'b0;
        nacked     = 1'b0;
        words_seen = 0;
        idle_cnt   = 0;
      end else if (in_xfer && scl_i && !scl_d) begin
        sample_bit();
      end

      if (in_xfer) begin
        // After a master NACK the slave stays off SDA until STOP.
        if (nacked) begin
          compare("sda_oe_o", 1'b0, sda_oe_i);
        end
        if (word_valid_i) begin
          words_seen = words_seen + 1;
          compare("word_o", exp_wr_word_i, word_i);
        end
      end else begin
        idle_cnt = idle_cnt + 1;
        // The DUT must not drive or publish anything on a quiet bus.
        if (idle_cnt > SETTLE) begin
          compare("sda_oe_o", 1'b0, sda_oe_i);
          compare("word_valid_o", 1'b0, word_valid_i);
        end
      end
      scl_d = scl_i;
      sda_d = sda_i;
    end
  end

endmodule

`default_nettype wire

// File: test/i2c_slave_tb.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_slave_tb;

  localparam logic [6:0] DEV_ADDR    = 7'h25;
  localparam int         DATA_WIDTH  = 32;
  localparam int         NBYTES      = DATA_WIDTH / i2c_pkg::byte_w;
  localparam int         NUM_ENTRIES = 9;
  localparam int         WATCHDOG_NS = NUM_ENTRIES * 6 * 9 * 40 * 4 + 10000;

  typedef enum logic [1:0] {op_write, op_read, op_load} op_e;

  typedef struct packed {
    op_e                   op;
    logic [6:0]            addr;
    logic [DATA_WIDTH-1:0] word;
    logic [3:0]            nbytes;
    logic                  ack;
  } entry_t;

  logic                  clk;
  logic                  rst;
  logic                  m_scl;
  logic                  m_sda_low;
  logic                  scl;
  logic                  sda;
  logic                  sda_oe;
  logic [DATA_WIDTH-1:0] word_out;
  logic                  word_valid;
  logic [DATA_WIDTH-1:0] word_in;
  logic                  word_load;
  logic                  exp_ack;
  logic [DATA_WIDTH-1:0] exp_wr_word;
  logic [DATA_WIDTH-1:0] exp_rd_word;
  int                    exp_words;
  int                    mon_errs;
  int                    mon_checks;
  int                    assert_fails;
  logic [31:0]           rng;
  entry_t                tbl [NUM_ENTRIES];

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Open-drain bus, pulled high unless a side pulls SDA low.
  assign scl = m_scl;
  assign sda = ~(m_sda_low | sda_oe);

  i2c_slave_top #(
    .DEV_ADDR   (DEV_ADDR),
    .DATA_WIDTH (DATA_WIDTH)
  ) dut_i (
    .clk          (clk),
    .rst          (rst),
    .scl_i        (scl),
    .sda_i        (sda),
    .sda_oe_o     (sda_oe),
    .word_o       (word_out),
    .word_valid_o (word_valid),
    .word_i       (word_in),
    .word_load_i  (word_load)
  );

  i2c_slave_mon #(
    .DATA_WIDTH (DATA_WIDTH)
  ) mon_i (
    .clk           (clk),
    .rst           (rst),
    .scl_i         (scl),
    .sda_i         (sda),
    .sda_oe_i      (sda_oe),
    .word_i        (word_out),
    .word_valid_i  (word_valid),
    .exp_ack_i     (exp_ack),
    .exp_wr_word_i (exp_wr_word),
    .exp_rd_word_i (exp_rd_word),
    .exp_words_i   (exp_words),
    .err_cnt_o     (mon_errs),
    .chk_cnt_o     (mon_checks)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic entry_t make_entry(input op_e op, input logic [6:0] addr,
                                        input int nbytes, input logic ack);
    entry_t e;
    e.op     = op;
    e.addr   = addr;
    e.word   = '0;
    e.nbytes = 4'(nbytes);
    e.ack    = ack;
    return e;
  endfunction

  task automatic fill_table();
    logic [DATA_WIDTH-1:0] last_load;
    last_load = '0;
    tbl[0] = make_entry(op_write, DEV_ADDR, 4, 1'b1);
    tbl[1] = make_entry(op_write, 7'h3a, 4, 1'b0);
    tbl[2] = make_entry(op_load, 7'h00, 0, 1'b0);
    tbl[3] = make_entry(op_read, DEV_ADDR, 4, 1'b1);
    tbl[4] = make_entry(op_read, DEV_ADDR, 6, 1'b1);
    tbl[5] = make_entry(op_read, DEV_ADDR, 2, 1'b1);
    tbl[6] = make_entry(op_write, DEV_ADDR, 4, 1'b1);
    tbl[7] = make_entry(op_write, DEV_ADDR, 2, 1'b1);
    tbl[8] = make_entry(op_write, DEV_ADDR, 4, 1'b1);
    // Reads expect the word of the latest load.
    for (int k = 0; k < NUM_ENTRIES; k++) begin
      if (tbl[k].op == op_read) begin
        tbl[k].word = last_load;
      end else begin
        rng = xorshift(rng);
        tbl[k].word = rng;
        if (tbl[k].op == op_load) begin
          last_load = rng;
        end
      end
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic issue_start();
    m_sda_low = 1'b0;
    m_scl     = 1'b1;
    wait_cycles(10);
    m_sda_low = 1'b1;
    wait_cycles(10);
    m_scl = 1'b0;
    wait_cycles(10);
  endtask

  task automatic issue_stop();
    m_sda_low = 1'b1;
    wait_cycles(10);
    m_scl = 1'b1;
    wait_cycles(10);
    m_sda_low = 1'b0;
    wait_cycles(20);
  endtask

  // One 40-cycle SCL period, data set up mid-way through the low phase.
  task automatic clock_bit(input logic b);
    m_sda_low = ~b;
    wait_cycles(10);
    m_scl = 1'b1;
    wait_cycles(20);
    m_scl = 1'b0;
    wait_cycles(10);
  endtask

  task automatic write_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      clock_bit(b[i]);
    end
    clock_bit(1'b1);
  endtask

  task automatic read_byte(input logic last);
    for (int i = 0; i < 8; i++) begin
      clock_bit(1'b1);
    end
    clock_bit(last);
  endtask

  task automatic apply_entry(input entry_t e);
    exp_ack     = e.ack;
    exp_wr_word = e.word;
    exp_rd_word = e.word;
    exp_words   = ((e.op == op_write) && e.ack) ? int'(e.nbytes) / NBYTES : 0;
    if (e.op == op_load) begin
      word_in   = e.word;
      word_load = 1'b1;
      wait_cycles(1);
      word_load = 1'b0;
      wait_cycles(4);
    end else begin
      issue_start();
      write_byte({e.addr, (e.op == op_read) ? i2c_pkg::rw_read : ~i2c_pkg::rw_read});
      for (int i = 0; i < int'(e.nbytes); i++) begin
        if (e.op == op_read) begin
          read_byte(i == int'(e.nbytes) - 1);
        end else begin
          write_byte(e.word[DATA_WIDTH-1-8*i -: 8]);
        end
      end
      issue_stop();
      wait_cycles(20);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the transactions did not complete within %0d ns", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    rst         = 1'b0;
    m_scl       = 1'b1;
    m_sda_low   = 1'b0;
    word_in     = '0;
    word_load   = 1'b0;
    exp_ack     = 1'b0;
    exp_wr_word = '0;
    exp_rd_word = '0;
    exp_words   = 0;
    rng         = 32'h209c;
    fill_table();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b1;
    // Idle bus first, the DUT has to stay quiet.
    wait_cycles(50);
    for (int k = 0; k < NUM_ENTRIES; k++) begin
      apply_entry(tbl[k]);
    end
    wait_cycles(20);
    assert_fails = dut_i.engine_i.chk_i.fail_cnt;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             mon_checks, mon_errs, assert_fails);
    if ((mon_errs == 0) && (assert_fails == 0)) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
rtl/i2c_pkg.sv
rtl/i2c_line_cond.sv
rtl/i2c_slave_engine.sv
rtl/i2c_mailbox.sv
rtl/i2c_slave_top.sv
test/i2c_slave_chk.sv
test/i2c_slave_mon.sv
test/i2c_slave_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module i2c_slave_tb \
  -f list.f -o i2c_slave_sim

status=0
./obj_dir/i2c_slave_sim +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"
